// ==== src/lane_pkg.sv ====
// Lane package
// Sizes, opcodes and the records that move down the SIMT lane pipeline

package lane_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	localparam int DATA_WIDTH   = 16;
	localparam int NUM_REGS     = 16;
	localparam int BANK_REGS    = NUM_REGS / 2;	// Even and odd banks
	localparam int BANK_WIDTH   = $clog2(BANK_REGS);
	localparam int INDEX_WIDTH  = 4;
	localparam int THREAD_WIDTH = 4;
	localparam int NUM_FLAGS    = 4;
	localparam int FLAG_WIDTH   = 2;
	localparam int OPCODE_WIDTH = 3;

	typedef logic [DATA_WIDTH-1:0]   data_t;
	typedef logic [INDEX_WIDTH-1:0]  index_t;
	typedef logic [BANK_WIDTH-1:0]   bank_addr_t;	// Row within one bank
	typedef logic [THREAD_WIDTH-1:0] thread_t;
	typedef logic [FLAG_WIDTH-1:0]   flag_sel_t;
	typedef logic [NUM_FLAGS-1:0]    mask_t;

	// Lane opcodes
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_ADD    = 3'd0,
		OP_SUB    = 3'd1,
		OP_MUL    = 3'd2,	// Low half of the product
		OP_AND    = 3'd3,
		OP_OR     = 3'd4,
		OP_XOR    = 3'd5,
		OP_CMP_LT = 3'd6	// Unsigned, result goes to a flag
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// Records
	typedef struct packed {
		index_t index;
		logic   slice;	// Offset by thread ID
	} operand_t;

	typedef struct packed {
		opcode_t   op;
		operand_t  src1;
		operand_t  src2;
		operand_t  dst;
		logic      use_imm;	// imm replaces src2
		data_t     imm;
		logic      masked;	// Predicated on flag
		flag_sel_t flag;
	} command_t;

	// Input record of the math unit
	typedef struct packed {
		logic    valid;
		opcode_t op;
		index_t  dst;
		data_t   src1;
		data_t   src2;
		logic    we;	// Cleared by predication
	} exe_t;

	// Register write-back
	typedef struct packed {
		logic   valid;
		index_t dst;
		data_t  data;
	} wb_t;

endpackage

// ==== src/lane_index_unit.sv ====
// Lane index unit
// Registers the effective register index of one operand. A sliced operand
// is offset by the thread ID and wraps around the register file.

`timescale 1ns/1ps

module lane_index_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                valid,
	input  lane_pkg::operand_t  operand,
	input  lane_pkg::thread_t   thread_id,
	output logic                index_valid,
	output lane_pkg::index_t    index
);

	// One spare bit so the wrap is explicit
	logic [lane_pkg::INDEX_WIDTH:0] slice_sum;
	lane_pkg::index_t               eff_index;

	assign slice_sum = operand.index + thread_id;

	always_comb begin
		if (operand.slice) begin
			eff_index = lane_pkg::index_t'(slice_sum % lane_pkg::NUM_REGS);
		end else begin
			eff_index = operand.index;
		end
	end

	// Valid travels with the index
	always_ff @(posedge clock) begin
		if (reset) begin
			index_valid <= 1'b0;
		end else begin
			index_valid <= valid;
		end
	end

	always_ff @(posedge clock) begin
		index <= eff_index;
	end

endmodule

// ==== src/lane_regfile.sv ====
// Lane register bank
// One bank of the lane register file, two registered read ports and one
// write port. Contents clear on reset.

`timescale 1ns/1ps

module lane_regfile (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  we,
	input  lane_pkg::bank_addr_t  write_index,
	input  lane_pkg::data_t       write_data,
	input  lane_pkg::bank_addr_t  read_index_a,
	input  lane_pkg::bank_addr_t  read_index_b,
	output lane_pkg::data_t       read_data_a,
	output lane_pkg::data_t       read_data_b
);

	lane_pkg::data_t mem [lane_pkg::BANK_REGS];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < lane_pkg::BANK_REGS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[write_index] <= write_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	// Same-edge write is not seen, old word comes out
	always_ff @(posedge clock) begin
		read_data_a <= mem[read_index_a];
		read_data_b <= mem[read_index_b];
	end

	// Write-back row must be resolved whenever the bank is written
	write_index_known: assert property (
		@(posedge clock) disable iff (reset)
		we |-> !$isunknown(write_index)
	) else $error("lane_regfile: unknown write_index with we high");

endmodule

// ==== src/lane_mask_reg.sv ====
// Lane mask register
// Condition flags written by compare write-back, read by predication

`timescale 1ns/1ps

module lane_mask_reg (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 we,
	input  lane_pkg::flag_sel_t  flag,
	input  logic                 cond,
	output lane_pkg::mask_t      mask
);

	lane_pkg::mask_t flags;

	// Only the selected flag changes
	always_ff @(posedge clock) begin
		if (reset) begin
			flags <= '0;
		end else if (we) begin
			flags[flag] <= cond;
		end
	end

	assign mask = flags;	// Combinational read

endmodule

// ==== src/lane_math_unit.sv ====
// Lane math unit
// Two-stage execution of lane opcodes. Stage one computes the result and
// the compare bit, stage two issues the register or flag write-back.

`timescale 1ns/1ps

module lane_math_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  lane_pkg::exe_t       exe,
	output lane_pkg::wb_t        wb,
	output logic                 flag_we,
	output lane_pkg::flag_sel_t  flag,
	output logic                 cond,
	output logic                 done
);

	logic             is_cmp;
	lane_pkg::data_t  result;

	logic             s1_valid;
	logic             s1_reg_we;	// Register write pending
	logic             s1_flag_we;	// Flag write pending
	lane_pkg::index_t s1_dst;
	lane_pkg::data_t  s1_result;
	logic             s1_cond;

	assign is_cmp = (exe.op == lane_pkg::OP_CMP_LT);

	always_comb begin
		case (exe.op)
			lane_pkg::OP_ADD: result = exe.src1 + exe.src2;
			lane_pkg::OP_SUB: result = exe.src1 - exe.src2;
			lane_pkg::OP_MUL: result = lane_pkg::data_t'(exe.src1 * exe.src2);
			lane_pkg::OP_AND: result = exe.src1 & exe.src2;
			lane_pkg::OP_OR:  result = exe.src1 | exe.src2;
			lane_pkg::OP_XOR: result = exe.src1 ^ exe.src2;
			default:          result = '0;	// Compare writes no register
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage one
	always_ff @(posedge clock) begin
		s1_dst    <= exe.dst;
		s1_result <= result;
		s1_cond   <= (exe.src1 < exe.src2);
		if (reset) begin
			s1_valid   <= 1'b0;
			s1_reg_we  <= 1'b0;
			s1_flag_we <= 1'b0;
		end else begin
			s1_valid   <= exe.valid;
			s1_reg_we  <= exe.valid & exe.we & ~is_cmp;
			s1_flag_we <= exe.valid & exe.we & is_cmp;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage two
	always_ff @(posedge clock) begin
		wb.dst  <= s1_dst;
		wb.data <= s1_result;
		flag    <= s1_dst[lane_pkg::FLAG_WIDTH-1:0];	// Flag number from dst
		cond    <= s1_cond;
		if (reset) begin
			wb.valid <= 1'b0;
			flag_we  <= 1'b0;
			done     <= 1'b0;
		end else begin
			wb.valid <= s1_reg_we;
			flag_we  <= s1_flag_we;
			done     <= s1_valid;	// Masked commands still finish
		end
	end

	// A command writes a register or a flag, never both
	wb_flag_exclusive: assert property (
		@(posedge clock) disable iff (reset)
		!(wb.valid && flag_we)
	) else $error("lane_math_unit: register and flag write together");

	write_implies_done: assert property (
		@(posedge clock) disable iff (reset)
		(wb.valid || flag_we) |-> done
	) else $error("lane_math_unit: write-back without done");

endmodule

// ==== src/lane_unit.sv ====
// SIMT vector lane
// Captures a command and thread ID, resolves register indices, reads the
// even and odd banks, executes, writes back and raises a commit request.
// Fixed four-cycle latency from command to commit.

`timescale 1ns/1ps

module lane_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                cmd_valid,
	input  lane_pkg::command_t  command,
	input  lane_pkg::thread_t   thread_id,
	output lane_pkg::wb_t       wb_out,
	output logic                commit,
	output lane_pkg::mask_t     mask_state
);

	// Fields that ride along with the indices
	typedef struct packed {
		lane_pkg::opcode_t   op;
		lane_pkg::data_t     imm;
		logic                masked;
		lane_pkg::flag_sel_t flag;
	} ctrl_t;

	logic               cap_valid;
	lane_pkg::command_t cap_cmd;
	lane_pkg::thread_t  cap_thread;

	logic               src1_valid, src2_valid, dst_valid;
	lane_pkg::index_t   src1_index, src2_index, dst_index;
	logic               idx_valid;
	ctrl_t              idx_ctrl;

	logic               rd_valid;
	ctrl_t              rd_ctrl;
	lane_pkg::index_t   rd_dst;
	logic               rd_sel1, rd_sel2;	// Odd bank selects
	logic               rd_src2_reg;	// src2 comes from a bank

	lane_pkg::data_t    even_a, even_b, odd_a, odd_b;
	lane_pkg::exe_t     exe;
	lane_pkg::wb_t      wb;
	logic               flag_we, cond, done;
	lane_pkg::flag_sel_t wb_flag;

	////////////////////////////////////////////////////////////////////////////
	// Command capture
	always_ff @(posedge clock) begin
		cap_cmd    <= command;
		cap_thread <= thread_id;
		if (reset) begin
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= cmd_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Index stage
	lane_index_unit index_src1 (
		.clock(clock), .reset(reset), .valid(cap_valid), .operand(cap_cmd.src1),
		.thread_id(cap_thread), .index_valid(src1_valid), .index(src1_index)
	);

	// No bank read for src2 when the immediate is used
	lane_index_unit index_src2 (
		.clock(clock), .reset(reset), .valid(cap_valid & ~cap_cmd.use_imm),
		.operand(cap_cmd.src2), .thread_id(cap_thread),
		.index_valid(src2_valid), .index(src2_index)
	);

	lane_index_unit index_dst (
		.clock(clock), .reset(reset), .valid(cap_valid), .operand(cap_cmd.dst),
		.thread_id(cap_thread), .index_valid(dst_valid), .index(dst_index)
	);

	assign idx_valid = src1_valid & dst_valid;	// Both follow the capture strobe

	always_ff @(posedge clock) begin
		idx_ctrl <= '{op: cap_cmd.op, imm: cap_cmd.imm, masked: cap_cmd.masked,
			flag: cap_cmd.flag};
	end

	////////////////////////////////////////////////////////////////////////////
	// Bank read and data select
	// Row is index/2, low bit picks the bank; src1 on port a, src2 on port b
	lane_regfile regfile_even (
		.clock(clock), .reset(reset),
		.we(wb.valid & ~wb.dst[0]), .write_index(wb.dst[lane_pkg::INDEX_WIDTH-1:1]),
		.write_data(wb.data),
		.read_index_a(src1_index[lane_pkg::INDEX_WIDTH-1:1]),
		.read_index_b(src2_index[lane_pkg::INDEX_WIDTH-1:1]),
		.read_data_a(even_a), .read_data_b(even_b)
	);

	lane_regfile regfile_odd (
		.clock(clock), .reset(reset),
		.we(wb.valid & wb.dst[0]), .write_index(wb.dst[lane_pkg::INDEX_WIDTH-1:1]),
		.write_data(wb.data),
		.read_index_a(src1_index[lane_pkg::INDEX_WIDTH-1:1]),
		.read_index_b(src2_index[lane_pkg::INDEX_WIDTH-1:1]),
		.read_data_a(odd_a), .read_data_b(odd_b)
	);

	always_ff @(posedge clock) begin
		rd_ctrl     <= idx_ctrl;
		rd_dst      <= dst_index;
		rd_sel1     <= src1_index[0];
		rd_sel2     <= src2_index[0];
		rd_src2_reg <= src2_valid;
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= idx_valid;
		end
	end

	// Predication against the current flags
	assign exe.valid = rd_valid;
	assign exe.op    = rd_ctrl.op;
	assign exe.dst   = rd_dst;
	assign exe.src1  = rd_sel1 ? odd_a : even_a;
	assign exe.src2  = rd_src2_reg ? (rd_sel2 ? odd_b : even_b) : rd_ctrl.imm;
	assign exe.we    = ~rd_ctrl.masked | mask_state[rd_ctrl.flag];

	////////////////////////////////////////////////////////////////////////////
	// Execution, write-back and commit
	lane_math_unit math_unit (
		.clock(clock), .reset(reset), .exe(exe), .wb(wb),
		.flag_we(flag_we), .flag(wb_flag), .cond(cond), .done(done)
	);

	lane_mask_reg mask_reg (
		.clock(clock), .reset(reset), .we(flag_we), .flag(wb_flag),
		.cond(cond), .mask(mask_state)
	);

	assign wb_out = wb;
	assign commit = done;

	// One commit per sampled command, four cycles later
	// Commit rises at the fourth edge and is first sampled at the fifth
	commit_latency: assert property (
		@(posedge clock) disable iff (reset)
		commit == $past(cmd_valid, 5)
	) else $error("lane_unit: commit not four cycles after cmd_valid");

endmodule

// ==== tests/lane_clock_gen.sv ====
// Lane testbench clock and reset
// 4 ns clock, reset held high for the first 16 rising edges

`timescale 1ns/1ps

module lane_clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;	// Released on an edge, seen by the DUT one cycle later
	end

endmodule

// ==== tests/lane_checker.sv ====
// Lane output checker
// Queues one expected record per issued command and compares commit,
// wb_out and mask_state with it five rising edges after the command edge

`timescale 1ns/1ps

module lane_checker (
	input  logic             clock,
	input  logic             reset,
	input  logic             cmd_valid,
	input  lane_pkg::wb_t    exp_wb,
	input  lane_pkg::mask_t  exp_mask,
	input  lane_pkg::wb_t    wb_out,
	input  logic             commit,
	input  lane_pkg::mask_t  mask_state,
	output int               value_errors,
	output int               event_errors,
	output logic             idle
);

	typedef struct {
		lane_pkg::wb_t   wb;
		lane_pkg::mask_t mask;	// Flags after this command
		int              due;	// Cycle where commit is sampled
	} pending_t;

	pending_t        pending[$];
	pending_t        head;
	lane_pkg::mask_t model_mask;
	int              cycle;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sampling on the rising edge sees the values of the cycle before it
	always @(posedge clock) begin
		if (reset) begin
			pending.delete();
			model_mask   = '0;
			cycle        = 0;
			value_errors = 0;
			event_errors = 0;
			idle         = 1'b1;
		end else begin
			cycle++;
			check_value("mask_state", 32'(model_mask), 32'(mask_state));
			if (pending.size() != 0 && pending[0].due == cycle) begin
				head = pending.pop_front();
				if (!commit) begin
					$display("Missing commit at %0t for a command issued five edges ago", $time);
					event_errors++;
				end else begin
					check_value("wb_out.valid", 32'(head.wb.valid), 32'(wb_out.valid));
					if (head.wb.valid && wb_out.valid) begin
						check_value("wb_out.dst", 32'(head.wb.dst), 32'(wb_out.dst));
						check_value("wb_out.data", 32'(head.wb.data), 32'(wb_out.data));
					end
				end
				model_mask = head.mask;	// Flag write lands on this edge
			end else begin
				if (commit) begin
					$display("Unexpected commit at %0t with no command due", $time);
					event_errors++;
				end
				check_value("wb_out.valid", 32'(0), 32'(wb_out.valid));
			end
			if (cmd_valid) begin
				pending.push_back('{wb: exp_wb, mask: exp_mask, due: cycle + 5});
			end
			idle = (pending.size() == 0);
		end
	end

endmodule

// ==== tests/tb_lane_unit.sv ====
// Lane unit testbench
// Drives a table of lane commands on falling edges, predicts each result
// with a reference model and passes the expectation to the checker

`timescale 1ns/1ps

module tb_lane_unit;

	typedef struct {
		lane_pkg::command_t cmd;
		lane_pkg::thread_t  thread;
		int                 idle;	// Idle cycles after the command
	} entry_t;

	logic               clock;
	logic               reset;
	logic               cmd_valid;
	lane_pkg::command_t command;
	lane_pkg::thread_t  thread_id;
	lane_pkg::wb_t      wb_out;
	logic               commit;
	lane_pkg::mask_t    mask_state;

	lane_pkg::wb_t      exp_wb;
	lane_pkg::mask_t    exp_mask;
	int                 value_errors;
	int                 event_errors;
	logic               checker_idle;

	entry_t             stim[$];
	lane_pkg::data_t    regs [lane_pkg::NUM_REGS];	// Reference register file
	lane_pkg::mask_t    flags;
	int                 cycles = 0;
	int                 limit = 0;

	lane_clock_gen clock_gen_i (.clock(clock), .reset(reset));

	lane_unit lane_unit_i (
		.clock(clock), .reset(reset), .cmd_valid(cmd_valid), .command(command),
		.thread_id(thread_id), .wb_out(wb_out), .commit(commit), .mask_state(mask_state)
	);

	lane_checker check_i (
		.clock(clock), .reset(reset), .cmd_valid(cmd_valid), .exp_wb(exp_wb),
		.exp_mask(exp_mask), .wb_out(wb_out), .commit(commit), .mask_state(mask_state),
		.value_errors(value_errors), .event_errors(event_errors), .idle(checker_idle)
	);

	////////////////////////////////////////////////////////////////////////////
	// Command table
	function automatic lane_pkg::command_t make_cmd(lane_pkg::opcode_t op, int src1,
			int src2, int dst, logic [2:0] slices, logic use_imm, lane_pkg::data_t imm);
		lane_pkg::command_t c;
		c         = '0;
		c.op      = op;
		c.src1    = '{index: lane_pkg::index_t'(src1), slice: slices[2]};
		c.src2    = '{index: lane_pkg::index_t'(src2), slice: slices[1]};
		c.dst     = '{index: lane_pkg::index_t'(dst), slice: slices[0]};
		c.use_imm = use_imm;
		c.imm     = imm;
		return c;
	endfunction

	function automatic lane_pkg::command_t with_mask(lane_pkg::command_t c, int flag);
		lane_pkg::command_t m;
		m        = c;
		m.masked = 1'b1;
		m.flag   = lane_pkg::flag_sel_t'(flag);
		return m;
	endfunction

	task automatic add_entry(lane_pkg::command_t c, int thread, int idle);
		stim.push_back('{cmd: c, thread: lane_pkg::thread_t'(thread), idle: idle});
	endtask

	task automatic build_table();
		lane_pkg::opcode_t alu_ops [6];
		alu_ops = '{lane_pkg::OP_ADD, lane_pkg::OP_SUB, lane_pkg::OP_MUL,
			lane_pkg::OP_AND, lane_pkg::OP_OR, lane_pkg::OP_XOR};
		// Random fill of every register, one per cycle, r0 last
		for (int r = lane_pkg::NUM_REGS - 1; r >= 0; r--) begin
			add_entry(make_cmd(lane_pkg::OP_OR, 0, 0, r, 3'b000, 1'b1,
				lane_pkg::data_t'($urandom)), 0, (r == 0) ? 3 : 0);
		end
		// Every opcode back to back, no result read within four cycles
		for (int i = 0; i < 12; i++) begin
			add_entry(make_cmd(alu_ops[i % 6], i, (i + 3) % 16, (i + 8) % 16, 3'b000,
				(i % 4) == 3, lane_pkg::data_t'(16'h00f0 + i)), 0, (i == 11) ? 3 : 0);
		end
		// Sliced operands, several wrap past register 15
		add_entry(make_cmd(lane_pkg::OP_ADD, 5, 10, 6, 3'b111, 1'b0, '0), 13, 3);
		add_entry(make_cmd(lane_pkg::OP_SUB, 15, 1, 14, 3'b101, 1'b0, '0), 15, 3);
		add_entry(make_cmd(lane_pkg::OP_XOR, 3, 0, 0, 3'b101, 1'b1, 16'h5a5a), 9, 3);
		add_entry(make_cmd(lane_pkg::OP_MUL, 0, 8, 12, 3'b011, 1'b0, '0), 4, 3);
		// Compares, flag number from the low dst bits
		add_entry(make_cmd(lane_pkg::OP_AND, 0, 0, 4, 3'b000, 1'b1, 16'h0000), 0, 3);
		add_entry(make_cmd(lane_pkg::OP_CMP_LT, 4, 0, 2, 3'b000, 1'b1, 16'h0001), 0, 3);
		add_entry(make_cmd(lane_pkg::OP_CMP_LT, 4, 0, 7, 3'b000, 1'b1, 16'h0001), 0, 3);
		add_entry(make_cmd(lane_pkg::OP_CMP_LT, 4, 0, 4, 3'b000, 1'b1, 16'h0000), 0, 3);
		add_entry(make_cmd(lane_pkg::OP_CMP_LT, 4, 0, 3, 3'b000, 1'b1, 16'h0000), 0, 3);
		// Predication, flag 1 clear and flag 2 set
		add_entry(with_mask(make_cmd(lane_pkg::OP_ADD, 1, 0, 9, 3'b000, 1'b1, 16'd5), 1), 0, 3);
		add_entry(with_mask(make_cmd(lane_pkg::OP_ADD, 1, 0, 9, 3'b000, 1'b1, 16'd5), 2), 0, 3);
		add_entry(with_mask(make_cmd(lane_pkg::OP_CMP_LT, 4, 0, 1, 3'b000, 1'b1,
			16'd1), 0), 0, 3);
		add_entry(with_mask(make_cmd(lane_pkg::OP_OR, 9, 2, 10, 3'b000, 1'b0, '0), 2), 0, 3);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	function automatic int effective_index(lane_pkg::operand_t o, lane_pkg::thread_t t);
		if (o.slice) begin
			return (int'(o.index) + int'(t)) % lane_pkg::NUM_REGS;
		end
		return int'(o.index);
	endfunction

	task automatic predict(input entry_t e, output lane_pkg::wb_t rec,
			output lane_pkg::mask_t m);
		lane_pkg::data_t a;
		lane_pkg::data_t b;
		lane_pkg::data_t r;
		int              d;
		logic            enable;
		a      = regs[effective_index(e.cmd.src1, e.thread)];
		b      = e.cmd.use_imm ? e.cmd.imm : regs[effective_index(e.cmd.src2, e.thread)];
		d      = effective_index(e.cmd.dst, e.thread);
		enable = !e.cmd.masked || flags[e.cmd.flag];
		rec    = '0;
		case (e.cmd.op)
			lane_pkg::OP_ADD: r = a + b;
			lane_pkg::OP_SUB: r = a - b;
			lane_pkg::OP_MUL: r = a * b;	// Truncated to the lane word
			lane_pkg::OP_AND: r = a & b;
			lane_pkg::OP_OR:  r = a | b;
			lane_pkg::OP_XOR: r = a ^ b;
			default:          r = '0;
		endcase
		if (e.cmd.op == lane_pkg::OP_CMP_LT) begin
			if (enable) begin
				flags[d % lane_pkg::NUM_FLAGS] = (a < b);
			end
		end else if (enable) begin
			regs[d]   = r;
			rec.valid = 1'b1;
			rec.dst   = lane_pkg::index_t'(d);
			rec.data  = r;
		end
		m = flags;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	initial begin
		cmd_valid = 1'b0;
		command   = '0;
		thread_id = '0;
		exp_wb    = '0;
		exp_mask  = '0;
		flags     = '0;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		void'($urandom(32'h797e_f68f));
		build_table();
		limit = stim.size() * 10 + 16 + 50;

		@(negedge reset);
		repeat (4) @(negedge clock);	// Quiet lane after reset
		foreach (stim[i]) begin
			predict(stim[i], exp_wb, exp_mask);
			command   = stim[i].cmd;
			thread_id = stim[i].thread;
			cmd_valid = 1'b1;
			@(negedge clock);
			cmd_valid = 1'b0;
			repeat (stim[i].idle) @(negedge clock);
		end

		while (!checker_idle) @(negedge clock);
		repeat (3) @(negedge clock);	// Last flag update and stray commits
		$display("Error counts: %0d value, %0d event", value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, commits still outstanding", cycles);
			$display("tests failed");
			$finish;
		end
	end

endmodule

// ==== lane.f ====
src/lane_pkg.sv
src/lane_index_unit.sv
src/lane_regfile.sv
src/lane_mask_reg.sv
src/lane_math_unit.sv
src/lane_unit.sv
tests/lane_clock_gen.sv
tests/lane_checker.sv
tests/tb_lane_unit.sv

// ==== Makefile ====
# Verilator build and run for the SIMT lane testbench

VERILATOR ?= verilator
TOP       ?= tb_lane_unit
FILELIST  ?= lane.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
